// File: Bender.yml
package:
  name: mem_uart

sources:
  - include_dirs:
      - .
    files:
      - bus_pkg.sv
      - rx_queue.sv
      - ram_uart.sv
      - mem_uart_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_chip_models.sv
      - tb_mem_uart.sv

// File: bus_consts.svh
`ifndef BUS_CONSTS_SVH
`define BUS_CONSTS_SVH

//////////////////////////////////////////////////////////////////////////////
// Address map
//////////////////////////////////////////////////////////////////////////////

// Single UART data port, everything else is SRAM
`define UART_ADDR 16'hBF00

//////////////////////////////////////////////////////////////////////////////
// Bus pacing and receive queue
//////////////////////////////////////////////////////////////////////////////

// Clocks per controller state = 2**BUS_DIV_LOG2
`define BUS_DIV_LOG2 2

`define QUEUE_DEPTH_LOG2 3

`endif

// File: bus_pkg.sv
package bus_pkg;

	`include "bus_consts.svh"

	typedef logic [15:0] mem_addr_t;
	typedef logic [15:0] mem_word_t;
	typedef logic [7:0] uart_byte_t;
	typedef logic [`QUEUE_DEPTH_LOG2-1:0] queue_ptr_t;
	typedef logic [31:0] access_tag_t;

	// Controller states, one bus tick each
	typedef enum logic [4:0] {
		IDLE,
		RX_WAIT, RX_STROBE, RX_LATCH, RX_DONE,
		TX_DRIVE, TX_STROBE, TX_WAIT_TBRE, TX_WAIT_TSRE, TX_DONE,
		RAM_RD_ADDR, RAM_RD_OE, RAM_RD_DONE,
		RAM_WR_ADDR, RAM_WR_WE, RAM_WR_DONE,
		POP_READ, POP_DONE
	} bus_state_t;

endpackage

// File: list.f
+incdir+.
bus_pkg.sv
rx_queue.sv
ram_uart.sv
mem_uart_top.sv
tb_chip_models.sv
tb_mem_uart.sv

// File: mem_uart_top.sv
`timescale 1ns/10ps

module mem_uart_top import bus_pkg::*; (
	input logic clk,
	input logic rst,

	input logic need_to_work,
	input logic mem_rd,
	input logic mem_wr,
	input mem_addr_t mem_addr,
	input mem_word_t mem_value,
	input access_tag_t mem_act,
	output mem_word_t result,
	output logic work_done,

	output mem_addr_t ram_addr,
	inout wire mem_word_t ram_data,
	output logic ram_en,
	output logic ram_oe,
	output logic ram_we,
	output logic rdn,
	output logic wrn,
	input logic data_ready,
	input logic tbre,
	input logic tsre
);

	logic push;
	uart_byte_t push_byte;
	logic pop;
	uart_byte_t head;
	logic empty;

	ram_uart u_ctrl (
		.clk(clk),
		.rst(rst),
		.need_to_work(need_to_work),
		.mem_rd(mem_rd),
		.mem_wr(mem_wr),
		.mem_addr(mem_addr),
		.mem_value(mem_value),
		.mem_act(mem_act),
		.result(result),
		.work_done(work_done),
		.ram_addr(ram_addr),
		.ram_data(ram_data),
		.ram_en(ram_en),
		.ram_oe(ram_oe),
		.ram_we(ram_we),
		.rdn(rdn),
		.wrn(wrn),
		.data_ready(data_ready),
		.tbre(tbre),
		.tsre(tsre),
		.push(push),
		.push_byte(push_byte),
		.pop(pop),
		.head(head),
		.empty(empty)
	);

	// Full only matters inside the queue
	rx_queue u_queue (
		.clk(clk),
		.rst(rst),
		.push(push),
		.push_byte(push_byte),
		.pop(pop),
		.head(head),
		.empty(empty),
		.full()
	);

endmodule

// File: ram_uart.sv
`timescale 1ns/10ps

`include "bus_consts.svh"

module ram_uart import bus_pkg::*; (
	input logic clk,
	input logic rst,

	// CPU side
	input logic need_to_work,
	input logic mem_rd,
	input logic mem_wr,
	input mem_addr_t mem_addr,
	input mem_word_t mem_value,
	input access_tag_t mem_act,
	output mem_word_t result,
	output logic work_done,

	// Chip side
	output mem_addr_t ram_addr,
	inout wire mem_word_t ram_data,
	output logic ram_en,
	output logic ram_oe,
	output logic ram_we,
	output logic rdn,
	output logic wrn,
	input logic data_ready,
	input logic tbre,
	input logic tsre,

	// Receive queue
	output logic push,
	output uart_byte_t push_byte,
	output logic pop,
	input uart_byte_t head,
	input logic empty
);

	logic [`BUS_DIV_LOG2-1:0] div_cnt;
	logic tick;

	bus_state_t state;
	bus_state_t state_next;

	logic done;
	access_tag_t last_tag;

	logic is_uart;
	logic new_req;
	logic accept;
	logic finish;
	logic bus_drive;

	//////////////////////////////////////////////////////////////////////////
	// Pacing and decode
	//////////////////////////////////////////////////////////////////////////

	assign tick = &div_cnt;
	assign is_uart = (mem_addr == `UART_ADDR);
	assign new_req = need_to_work && (mem_act != last_tag);

	assign ram_addr = mem_addr;
	assign ram_data = bus_drive ? mem_value : 'z;
	assign push_byte = ram_data[7:0];

	// Single-clock pulses on the tick that leaves the state
	assign push = tick && (state == RX_LATCH);
	assign pop = tick && (state == POP_READ);

	assign work_done = done && (mem_act == last_tag);

	//////////////////////////////////////////////////////////////////////////
	// Next state
	//////////////////////////////////////////////////////////////////////////

	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				// Receive wins over CPU work
				if (data_ready)
					state_next = RX_WAIT;
				else if (new_req && is_uart) begin
					if (mem_wr)
						state_next = TX_DRIVE;
					else if (mem_rd)
						state_next = POP_READ;
				end else if (new_req) begin
					if (mem_wr)
						state_next = RAM_WR_ADDR;
					else if (mem_rd)
						state_next = RAM_RD_ADDR;
				end
			end
			RX_WAIT: state_next = data_ready ? RX_STROBE : IDLE;
			RX_STROBE: state_next = RX_LATCH;
			RX_LATCH: state_next = RX_DONE;
			RX_DONE: state_next = IDLE;
			TX_DRIVE: state_next = TX_STROBE;
			TX_STROBE: state_next = TX_WAIT_TBRE;
			TX_WAIT_TBRE: begin
				if (tbre)
					state_next = TX_WAIT_TSRE;
			end
			TX_WAIT_TSRE: begin
				if (tsre)
					state_next = TX_DONE;
			end
			TX_DONE: state_next = IDLE;
			RAM_RD_ADDR: state_next = RAM_RD_OE;
			RAM_RD_OE: state_next = RAM_RD_DONE;
			RAM_RD_DONE: state_next = IDLE;
			RAM_WR_ADDR: state_next = RAM_WR_WE;
			RAM_WR_WE: state_next = RAM_WR_DONE;
			RAM_WR_DONE: state_next = IDLE;
			POP_READ: state_next = POP_DONE;
			POP_DONE: state_next = IDLE;
			default: state_next = IDLE;
		endcase
	end

	assign accept = (state == IDLE) && (state_next != IDLE) && (state_next != RX_WAIT);
	assign finish = (state == RAM_RD_DONE) || (state == RAM_WR_DONE) ||
		(state == TX_DONE) || (state == POP_DONE);

	//////////////////////////////////////////////////////////////////////////
	// State, done flag and tag
	//////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			div_cnt <= '0;
			state <= IDLE;
			done <= 1'b0;
			last_tag <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
			if (tick) begin
				state <= state_next;
				if (accept)
					done <= 1'b0;
				if (finish) begin
					done <= 1'b1;
					last_tag <= mem_act;
				end
			end
		end
	end

	// Read data, sampled while the source is still enabled
	always_ff @(posedge clk) begin
		if (tick) begin
			if (state == RAM_RD_OE)
				result <= ram_data;
			else if (state == POP_READ)
				result <= empty ? '0 : mem_word_t'(head);
		end
	end

	//////////////////////////////////////////////////////////////////////////
	// Chip strobes
	//////////////////////////////////////////////////////////////////////////

	always_comb begin
		ram_en = 1'b1;
		ram_oe = 1'b1;
		ram_we = 1'b1;
		rdn = 1'b1;
		wrn = 1'b1;
		bus_drive = 1'b0;
		case (state)
			RAM_RD_ADDR, RAM_RD_DONE: ram_en = 1'b0;
			RAM_RD_OE: begin
				ram_en = 1'b0;
				ram_oe = 1'b0;
			end
			RAM_WR_ADDR, RAM_WR_DONE: begin
				ram_en = 1'b0;
				bus_drive = 1'b1;
			end
			RAM_WR_WE: begin
				ram_en = 1'b0;
				ram_we = 1'b0;
				bus_drive = 1'b1;
			end
			// Data held one state past the wrn rising edge
			TX_DRIVE, TX_WAIT_TBRE: bus_drive = 1'b1;
			TX_STROBE: begin
				wrn = 1'b0;
				bus_drive = 1'b1;
			end
			RX_STROBE, RX_LATCH: rdn = 1'b0;
			default: ;
		endcase
	end

	a_oe_we: assert property (@(posedge clk) disable iff (!rst) ram_oe || ram_we);

	a_rdn_wrn: assert property (@(posedge clk) disable iff (!rst) rdn || wrn);

	a_bus_contention: assert property (@(posedge clk) disable iff (!rst)
		!(bus_drive && (!ram_oe || !rdn)));

endmodule

// File: rx_queue.sv
`timescale 1ns/10ps

`include "bus_consts.svh"

module rx_queue import bus_pkg::*; (
	input logic clk,
	input logic rst,
	input logic push,
	input uart_byte_t push_byte,
	input logic pop,
	output uart_byte_t head,
	output logic empty,
	output logic full
);

	localparam int DEPTH = 1 << `QUEUE_DEPTH_LOG2;

	uart_byte_t mem [DEPTH];

	// Pointers with one extra wrap bit
	logic [`QUEUE_DEPTH_LOG2:0] wr_ptr;
	logic [`QUEUE_DEPTH_LOG2:0] rd_ptr;
	logic [`QUEUE_DEPTH_LOG2:0] ptr_span;
	queue_ptr_t wr_idx;
	queue_ptr_t rd_idx;

	assign wr_idx = wr_ptr[`QUEUE_DEPTH_LOG2-1:0];
	assign rd_idx = rd_ptr[`QUEUE_DEPTH_LOG2-1:0];

	// Fill level, modulo the wrap bit
	assign ptr_span = wr_ptr - rd_ptr;

	assign empty = (wr_ptr == rd_ptr);
	assign full = (wr_ptr[`QUEUE_DEPTH_LOG2] != rd_ptr[`QUEUE_DEPTH_LOG2]) &&
		(wr_idx == rd_idx);
	assign head = mem[rd_idx];

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			// Overflow bytes are simply dropped
			if (push && !full)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop && !empty)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push && !full)
			mem[wr_idx] <= push_byte;
	end

	a_ptr_span: assert property (@(posedge clk) disable iff (!rst)
		ptr_span <= DEPTH);

endmodule

// File: tb_chip_models.sv
`timescale 1ns/10ps

// Asynchronous SRAM, 64K words
module sram_model import bus_pkg::*; (
	input mem_addr_t ram_addr,
	inout wire mem_word_t ram_data,
	input logic ram_en,
	input logic ram_oe,
	input logic ram_we
);

	mem_word_t mem [0:65535];
	int write_count = 0;

	assign ram_data = (!ram_en && !ram_oe) ? mem[ram_addr] : 'z;

	always @(posedge ram_we) begin
		if (!ram_en) begin
			mem[ram_addr] = ram_data;
			write_count++;
		end
	end

endmodule

// Serial chip with byte-wide data on the low half of the bus
module uart_chip_model import bus_pkg::*; (
	input logic clk,
	input logic rst,
	input logic rdn,
	input logic wrn,
	inout wire mem_word_t ram_data,
	output logic data_ready,
	output logic tbre,
	output logic tsre
);

	uart_byte_t rx_byte;
	uart_byte_t tx_list [$];

	assign ram_data = !rdn ? {8'h00, rx_byte} : 'z;

	initial begin
		rx_byte = '0;
		data_ready = 1'b0;
		tbre = 1'b1;
		tsre = 1'b1;
	end

	task automatic send_byte(input uart_byte_t b);
		rx_byte = b;
		data_ready = 1'b1;
	endtask

	always @(negedge rdn) begin
		data_ready = 1'b0;
	end

	// Transmit buffer busy, then shift register busy
	always @(posedge wrn) begin
		if (rst) begin
			tx_list.push_back(ram_data[7:0]);
			tbre = 1'b0;
			tsre = 1'b0;
			repeat (6) @(posedge clk);
			tbre = 1'b1;
			repeat (5) @(posedge clk);
			tsre = 1'b1;
		end
	end

endmodule

// File: tb_mem_uart.sv
`timescale 1ns/10ps

`include "bus_consts.svh"

module tb_mem_uart import bus_pkg::*; ();

	localparam int DEPTH = 1 << `QUEUE_DEPTH_LOG2;
	localparam int WAIT_LIMIT = 400;

	logic clk;
	logic rst;
	logic need_to_work;
	logic mem_rd;
	logic mem_wr;
	mem_addr_t mem_addr;
	mem_word_t mem_value;
	access_tag_t mem_act;
	mem_word_t result;
	logic work_done;
	mem_addr_t ram_addr;
	wire mem_word_t ram_data;
	logic ram_en;
	logic ram_oe;
	logic ram_we;
	logic rdn;
	logic wrn;
	logic data_ready;
	logic tbre;
	logic tsre;

	logic [31:0] lfsr_state;
	mem_word_t shadow [mem_addr_t];
	uart_byte_t ref_queue [$];
	uart_byte_t tx_expect [$];
	mem_addr_t wr_addrs [$];
	mem_word_t exp_result;
	logic check_pending;
	int checks;
	int errors;

	mem_uart_top uut (
		.clk(clk),
		.rst(rst),
		.need_to_work(need_to_work),
		.mem_rd(mem_rd),
		.mem_wr(mem_wr),
		.mem_addr(mem_addr),
		.mem_value(mem_value),
		.mem_act(mem_act),
		.result(result),
		.work_done(work_done),
		.ram_addr(ram_addr),
		.ram_data(ram_data),
		.ram_en(ram_en),
		.ram_oe(ram_oe),
		.ram_we(ram_we),
		.rdn(rdn),
		.wrn(wrn),
		.data_ready(data_ready),
		.tbre(tbre),
		.tsre(tsre)
	);

	sram_model sram (
		.ram_addr(ram_addr),
		.ram_data(ram_data),
		.ram_en(ram_en),
		.ram_oe(ram_oe),
		.ram_we(ram_we)
	);

	uart_chip_model uart (
		.clk(clk),
		.rst(rst),
		.rdn(rdn),
		.wrn(wrn),
		.ram_data(ram_data),
		.data_ready(data_ready),
		.tbre(tbre),
		.tsre(tsre)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Random source and reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic logic lfsr_bit();
		logic b;
		b = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (b)
			lfsr_state = lfsr_state ^ 32'h8020_0003;
		return b;
	endfunction

	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[14:0], lfsr_bit()};
		return v;
	endfunction

	// Expected CPU result, updates shadow memory and byte queues
	function automatic mem_word_t ref_access(input logic wr, input mem_addr_t addr,
		input mem_word_t value);
		mem_word_t r;
		r = '0;
		if (addr == `UART_ADDR) begin
			if (wr)
				tx_expect.push_back(value[7:0]);
			else if (ref_queue.size() > 0)
				r = {8'h00, ref_queue.pop_front()};
		end else if (wr) begin
			shadow[addr] = value;
		end else begin
			r = shadow[addr];
		end
		return r;
	endfunction

	// Bytes beyond the queue depth are lost
	function automatic void ref_receive(input uart_byte_t b);
		if (ref_queue.size() < DEPTH)
			ref_queue.push_back(b);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	task automatic check_word(input mem_word_t actual, input mem_word_t expected,
		input string what);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[FAIL] %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
		end
	endtask

	task automatic check_byte(input uart_byte_t actual, input uart_byte_t expected,
		input string what);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[FAIL] %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
		end
	endtask

	always @(negedge clk) begin
		if (check_pending && work_done) begin
			check_word(result, exp_result, $sformatf("read of %h", mem_addr));
			check_pending = 1'b0;
		end
	end

	task automatic abort_run(input string what);
		$display("Timeout: %s did not complete", what);
		$display("SIMULATION FAILED");
		$finish;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	task automatic cpu_access(input logic wr, input mem_addr_t addr, input mem_word_t value);
		int n;
		@(posedge clk);
		#10;
		mem_act = mem_act + 1;
		need_to_work = 1'b1;
		mem_rd = !wr;
		mem_wr = wr;
		mem_addr = addr;
		mem_value = value;
		exp_result = ref_access(wr, addr, value);
		check_pending = !wr;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!work_done && n < WAIT_LIMIT);
		if (!work_done)
			abort_run("CPU access");
	endtask

	task automatic inject_byte(input uart_byte_t b);
		int n;
		@(posedge clk);
		#10;
		uart.send_byte(b);
		ref_receive(b);
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while ((data_ready || !rdn) && n < WAIT_LIMIT);
		if (data_ready || !rdn)
			abort_run("Byte receive");
	endtask

	function automatic mem_addr_t rand_addr();
		mem_addr_t a;
		a = rand_bits(16);
		if (a == `UART_ADDR)
			a[0] = ~a[0];
		return a;
	endfunction

	initial begin
		int count_before;
		rst = 1'b0;
		need_to_work = 1'b0;
		mem_rd = 1'b0;
		mem_wr = 1'b0;
		mem_addr = '0;
		mem_value = '0;
		mem_act = '0;
		exp_result = '0;
		check_pending = 1'b0;
		checks = 0;
		errors = 0;
		lfsr_state = 32'd86874;
		repeat (8) @(posedge clk);
		#10 rst = 1'b1;

		// SRAM writes, then reads back
		for (int i = 0; i < 8; i++) begin
			wr_addrs.push_back(rand_addr());
			cpu_access(1'b1, wr_addrs[i], rand_bits(16));
		end
		foreach (wr_addrs[i])
			cpu_access(1'b0, wr_addrs[i], '0);

		// UART transmit
		for (int i = 0; i < 4; i++)
			cpu_access(1'b1, `UART_ADDR, rand_bits(16));

		// UART receive in order
		for (int i = 0; i < 3; i++)
			inject_byte(uart_byte_t'(rand_bits(8)));
		for (int i = 0; i < 3; i++)
			cpu_access(1'b0, `UART_ADDR, '0);

		// Empty queue reads zero
		cpu_access(1'b0, `UART_ADDR, '0);
		inject_byte(uart_byte_t'(rand_bits(8)));
		cpu_access(1'b0, `UART_ADDR, '0);

		// Same tag held, no repeated write
		cpu_access(1'b1, rand_addr(), rand_bits(16));
		count_before = sram.write_count;
		repeat (40) begin
			@(negedge clk);
			if (!work_done) begin
				errors++;
				$display("[FAIL] %0t ns: work_done went low while the tag was held", $time);
			end
		end
		checks++;
		if (sram.write_count != count_before) begin
			errors++;
			$display("[FAIL] %0t ns: SRAM write count %0d, expected %0d", $time,
				sram.write_count, count_before);
		end

		// Overflow drops the extra bytes
		for (int i = 0; i < DEPTH + 3; i++)
			inject_byte(uart_byte_t'(rand_bits(8)));
		for (int i = 0; i < DEPTH + 1; i++)
			cpu_access(1'b0, `UART_ADDR, '0);

		repeat (4) @(posedge clk);
		if (uart.tx_list.size() != tx_expect.size()) begin
			errors++;
			$display("UART chip received %0d bytes, expected %0d",
				uart.tx_list.size(), tx_expect.size());
		end else begin
			foreach (tx_expect[i])
				check_byte(uart.tx_list[i], tx_expect[i], $sformatf("transmit byte %0d", i));
		end

		$display("Checks: %0d  Errors: %0d", checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule
